/* design/core_pkg.sv */
/*
  Shared definitions for the wb_clk control plane.
  Settings addresses are word addresses (byte address bits 9:2) inside
  the settings window. Window decode looks at byte address bits 15:8 only.
  Readback indices select 32-bit words inside the 64-byte readback window.
*/
package core_pkg;

   //////////////////////////////
   // Bus widths
   //////////////////////////////
   localparam int WB_DW  = 32;
   localparam int WB_AW  = 16;
   localparam int WB_SW  = 4;
   localparam int SET_AW = 8;

   // Window decode on adr[15:8]
   localparam logic [7:0] SET_WIN_BASE = 8'h70;
   localparam logic [7:0] SET_WIN_MASK = 8'hF0;
   localparam logic [7:0] RB_WIN_BASE  = 8'h5C;
   localparam logic [7:0] RB_WIN_MASK  = 8'hFC;

   //////////////////////////////
   // Settings bus map
   //////////////////////////////
   localparam logic [SET_AW-1:0] SR_MISC   = 8'd0;
   localparam logic [SET_AW-1:0] SR_TIME64 = 8'd10;
   localparam logic [SET_AW-1:0] SR_DIVSW  = 8'd180;

   // Offsets from SR_MISC
   localparam logic [SET_AW-1:0] SR_LMS_RES_OFS = 8'd0;
   localparam logic [SET_AW-1:0] SR_LED_SW_OFS  = 8'd3;
   localparam logic [SET_AW-1:0] SR_PHY_OFS     = 8'd4;
   localparam logic [SET_AW-1:0] SR_BLDR_OFS    = 8'd5;
   localparam logic [SET_AW-1:0] SR_LED_SRC_OFS = 8'd6;

   // Offsets from SR_TIME64
   localparam logic [SET_AW-1:0] SR_TIME_HI_OFS = 8'd0;
   localparam logic [SET_AW-1:0] SR_TIME_LO_OFS = 8'd1;

   // Reset values and constants
   localparam logic [7:0]       LED_SRC_RESET = 8'h1E;
   localparam logic             DIVSW_RESET   = 1'b1;
   localparam logic [WB_DW-1:0] COMPAT_NUM    = {16'd9, 16'd0};

   // Readback word indices
   localparam logic [3:0] RB_TIME_HI     = 4'd10;
   localparam logic [3:0] RB_TIME_LO     = 4'd11;
   localparam logic [3:0] RB_COMPAT      = 4'd12;
   localparam logic [3:0] RB_MISC_STATUS = 4'd13;
   localparam logic [3:0] RB_PPS_HI      = 4'd14;
   localparam logic [3:0] RB_PPS_LO      = 4'd15;

   // Bootloader reset controller states
   typedef enum logic {
      BLDR_WAIT = 1'b0,
      BLDR_DONE = 1'b1
   } bldr_state_t;

   //////////////////////////////
   // Bus structs
   //////////////////////////////
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [WB_AW-1:0] adr;
      logic [WB_SW-1:0] sel;
      logic [WB_DW-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic             ack;
      logic [WB_DW-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic              stb;
      logic [SET_AW-1:0] addr;
      logic [WB_DW-1:0]  data;
   } set_bus_t;

endpackage

/* design/wb_decoder.sv */
/*
  Wishbone classic slave, single access in flight.
  The master must hold adr/we/dat until ack and drop stb the cycle after ack.
  Ack comes two cycles after stb is first sampled. Settings writes are
  full-word and sel is not checked. Unmapped accesses ack with zero data.
*/
`timescale 1ns/1ps

module wb_decoder (
   input  logic                        wb_clk,
   input  logic                        soft_rst_i,
   input  core_pkg::wb_req_t           wb_req_i,
   output core_pkg::wb_rsp_t           wb_rsp_o,
   output core_pkg::set_bus_t          set_bus_o,
   output logic [3:0]                  rb_index_o,
   input  logic [core_pkg::WB_DW-1:0]  rb_data_i
);

   logic                          set_hit;
   logic                          rb_hit;
   logic                          start;
   logic                          busy_q;
   logic                          pend_q;
   logic                          ack_q;
   logic                          rd_rb_q;
   logic [core_pkg::WB_DW-1:0]    dat_q;
   logic                          set_stb_q;
   logic [core_pkg::SET_AW-1:0]   set_addr_q;
   logic [core_pkg::WB_DW-1:0]    set_data_q;

   assign set_hit = (wb_req_i.adr[15:8] & core_pkg::SET_WIN_MASK) == core_pkg::SET_WIN_BASE;
   assign rb_hit  = (wb_req_i.adr[15:8] & core_pkg::RB_WIN_MASK) == core_pkg::RB_WIN_BASE;
   assign start   = wb_req_i.cyc & wb_req_i.stb & ~busy_q;

   // Readback mux registers this word on the accepting edge
   assign rb_index_o = wb_req_i.adr[5:2];

   //////////////////////////////
   // Access tracking
   //////////////////////////////
   always_ff @(posedge wb_clk) begin
      if (soft_rst_i) begin
         busy_q    <= 1'b0;
         pend_q    <= 1'b0;
         ack_q     <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         pend_q    <= start;
         ack_q     <= pend_q;
         set_stb_q <= start & wb_req_i.we & set_hit;
         // Busy until the ack cycle has passed, stb is still high then
         if (start) begin
            busy_q <= 1'b1;
         end else if (ack_q) begin
            busy_q <= 1'b0;
         end
      end
   end

   // Settings payload and response data
   always_ff @(posedge wb_clk) begin
      if (start) begin
         set_addr_q <= wb_req_i.adr[9:2];
         set_data_q <= wb_req_i.dat;
         rd_rb_q    <= ~wb_req_i.we & rb_hit;
      end
      if (pend_q) begin
         dat_q <= rd_rb_q ? rb_data_i : '0;
      end
   end

   assign wb_rsp_o.ack   = ack_q;
   assign wb_rsp_o.dat   = dat_q;
   assign set_bus_o.stb  = set_stb_q;
   assign set_bus_o.addr = set_addr_q;
   assign set_bus_o.data = set_data_q;

endmodule

/* design/settings_regs.sv */
/*
  Setting registers on the wb_clk settings bus.
  A register updates on the edge after its strobe cycle.
  LED source bit 1 selects the hardware run flag, 0 the software value.
  Only run flags exist as hardware LED sources, in bits 4:1.
*/
`timescale 1ns/1ps

module settings_regs (
   input  logic                wb_clk,
   input  logic                soft_rst_i,
   input  core_pkg::set_bus_t  set_bus_i,
   input  logic [3:0]          run_i,
   output logic [1:0]          lms_res_o,
   output logic                phy_reset_n_o,
   output logic                div_sw1_o,
   output logic                div_sw2_o,
   output logic [7:0]          leds_o,
   output logic                bldr_done_o
);

   logic [1:0] lms_res_q;
   logic [7:0] led_sw_q;
   logic [7:0] led_src_q;
   logic       phy_rst_q;
   logic       bldr_done_q;
   logic       div_sw1_q;
   logic       div_sw2_q;
   logic [7:0] led_hw;

   //////////////////////////////
   // Register writes
   //////////////////////////////
   always_ff @(posedge wb_clk) begin
      if (soft_rst_i) begin
         lms_res_q   <= '0;
         led_sw_q    <= '0;
         led_src_q   <= core_pkg::LED_SRC_RESET;
         phy_rst_q   <= 1'b0;
         bldr_done_q <= 1'b0;
         div_sw1_q   <= core_pkg::DIVSW_RESET;
         div_sw2_q   <= core_pkg::DIVSW_RESET;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            core_pkg::SR_MISC + core_pkg::SR_LMS_RES_OFS: lms_res_q <= set_bus_i.data[1:0];
            core_pkg::SR_MISC + core_pkg::SR_LED_SW_OFS:  led_sw_q  <= set_bus_i.data[7:0];
            core_pkg::SR_MISC + core_pkg::SR_PHY_OFS:     phy_rst_q <= set_bus_i.data[0];
            core_pkg::SR_MISC + core_pkg::SR_BLDR_OFS:    bldr_done_q <= set_bus_i.data[0];
            core_pkg::SR_MISC + core_pkg::SR_LED_SRC_OFS: led_src_q <= set_bus_i.data[7:0];
            core_pkg::SR_DIVSW:                           div_sw1_q <= set_bus_i.data[0];
            core_pkg::SR_DIVSW + 8'd1:                    div_sw2_q <= set_bus_i.data[0];
            default: begin
            end
         endcase
      end
   end

   //////////////////////////////
   // LED mix
   //////////////////////////////
   // Run flags sit above bit 0, upper bits have no hardware source
   assign led_hw = {3'b000, run_i, 1'b0};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_rst_q;
   assign lms_res_o     = lms_res_q;
   assign div_sw1_o     = div_sw1_q;
   assign div_sw2_o     = div_sw2_q;
   assign bldr_done_o   = bldr_done_q;

endmodule

/* design/vita_timer.sv */
/*
  64-bit VITA time counter, one tick per wb_clk.
  Software writes TIME_HI first, then TIME_LO; the TIME_LO write loads both.
  pps_i is asynchronous and goes through a two-flop synchronizer, so the
  captured time lags the pin by three cycles.
*/
`timescale 1ns/1ps

module vita_timer (
   input  logic                wb_clk,
   input  logic                soft_rst_i,
   input  core_pkg::set_bus_t  set_bus_i,
   input  logic                pps_i,
   output logic [63:0]         vita_time_o,
   output logic [63:0]         vita_time_pps_o
);

   logic        time_hi_wr;
   logic        time_lo_wr;
   logic [31:0] time_hi_stage;
   logic [63:0] time_q;
   logic [63:0] pps_time_q;
   logic        pps_meta;
   logic        pps_sync;
   logic        pps_last;
   logic        pps_rise;

   assign time_hi_wr = set_bus_i.stb &&
                       (set_bus_i.addr == core_pkg::SR_TIME64 + core_pkg::SR_TIME_HI_OFS);
   assign time_lo_wr = set_bus_i.stb &&
                       (set_bus_i.addr == core_pkg::SR_TIME64 + core_pkg::SR_TIME_LO_OFS);

   assign pps_rise = pps_sync & ~pps_last;

   // High word waits here for the low word write
   always_ff @(posedge wb_clk) begin
      if (time_hi_wr) begin
         time_hi_stage <= set_bus_i.data;
      end
   end

   //////////////////////////////
   // Counter and PPS capture
   //////////////////////////////
   always_ff @(posedge wb_clk) begin
      if (soft_rst_i) begin
         time_q     <= '0;
         pps_time_q <= '0;
         pps_meta   <= 1'b0;
         pps_sync   <= 1'b0;
         pps_last   <= 1'b0;
      end else begin
         if (time_lo_wr) begin
            time_q <= {time_hi_stage, set_bus_i.data};
         end else begin
            time_q <= time_q + 64'd1;
         end
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_last <= pps_sync;
         if (pps_rise) begin
            pps_time_q <= time_q;
         end
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = pps_time_q;

endmodule

/* design/readback_mux.sv */
/*
  Registered 16-word readback selection, one cycle from index to data.
  Words without a source read zero, the router status word included.
  aux_ld_i and button_i are sampled without synchronization.
*/
`timescale 1ns/1ps

module readback_mux (
   input  logic                        wb_clk,
   input  logic                        soft_rst_i,
   input  logic [3:0]                  rb_index_i,
   input  logic [63:0]                 vita_time_i,
   input  logic [63:0]                 vita_time_pps_i,
   input  logic [1:0]                  aux_ld_i,
   input  logic                        button_i,
   output logic [core_pkg::WB_DW-1:0]  rb_data_o
);

   logic [core_pkg::WB_DW-1:0] status_word;
   logic [core_pkg::WB_DW-1:0] rb_data_q;

   // Lock detects and button in bits 18:16
   assign status_word = {13'd0, aux_ld_i[1], aux_ld_i[0], button_i, 16'd0};

   always_ff @(posedge wb_clk) begin
      if (soft_rst_i) begin
         rb_data_q <= '0;
      end else begin
         case (rb_index_i)
            core_pkg::RB_TIME_HI:     rb_data_q <= vita_time_i[63:32];
            core_pkg::RB_TIME_LO:     rb_data_q <= vita_time_i[31:0];
            core_pkg::RB_COMPAT:      rb_data_q <= core_pkg::COMPAT_NUM;
            core_pkg::RB_MISC_STATUS: rb_data_q <= status_word;
            core_pkg::RB_PPS_HI:      rb_data_q <= vita_time_pps_i[63:32];
            core_pkg::RB_PPS_LO:      rb_data_q <= vita_time_pps_i[31:0];
            default:                  rb_data_q <= '0;
         endcase
      end
   end

   assign rb_data_o = rb_data_q;

endmodule

/* design/boot_reset_ctrl.sv */
/*
  Soft reset for the whole core.
  soft_rst_o follows por_rst and stays high one cycle after it falls.
  The first bldr_done_i after por_rst gives one more soft reset cycle;
  later writes are ignored until the next por_rst.
*/
`timescale 1ns/1ps

module boot_reset_ctrl (
   input  logic wb_clk,
   input  logic por_rst,
   input  logic bldr_done_i,
   output logic soft_rst_o
);

   core_pkg::bldr_state_t state_q;
   logic                  soft_rst_q;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state_q    <= core_pkg::BLDR_WAIT;
         soft_rst_q <= 1'b1;
      end else begin
         case (state_q)
            core_pkg::BLDR_WAIT: begin
               soft_rst_q <= 1'b0;
               // Bootloader has handed over, restart the core once
               if (bldr_done_i) begin
                  state_q    <= core_pkg::BLDR_DONE;
                  soft_rst_q <= 1'b1;
               end
            end
            default: begin
               soft_rst_q <= 1'b0;
            end
         endcase
      end
   end

   assign soft_rst_o = soft_rst_q;

endmodule

/* design/umtrx_ctrl_core.sv */
/*
  wb_clk control plane of the radio core.
  Bus decode feeds the settings bus, which feeds the setting registers and
  the time counter. All state is cleared by the internal soft reset.
  run_i carries {tx0, rx0, tx1, rx1} run flags from outside the core.
*/
`timescale 1ns/1ps

module umtrx_ctrl_core (
   input  logic               wb_clk,
   input  logic               por_rst,
   input  core_pkg::wb_req_t  wb_req_i,
   output core_pkg::wb_rsp_t  wb_rsp_o,
   input  logic [3:0]         run_i,
   input  logic               pps_i,
   input  logic [1:0]         aux_ld_i,
   input  logic               button_i,
   output logic [1:0]         lms_res_o,
   output logic               phy_reset_n_o,
   output logic               div_sw1_o,
   output logic               div_sw2_o,
   output logic [7:0]         leds_o
);

   logic                       soft_rst;
   logic                       bldr_done;
   core_pkg::set_bus_t         set_bus;
   logic [3:0]                 rb_index;
   logic [core_pkg::WB_DW-1:0] rb_data;
   logic [63:0]                vita_time;
   logic [63:0]                vita_time_pps;

   //////////////////////////////
   // Bus decode stage
   //////////////////////////////
   wb_decoder i_wb_decoder (
      .wb_clk     (wb_clk),
      .soft_rst_i (soft_rst),
      .wb_req_i   (wb_req_i),
      .wb_rsp_o   (wb_rsp_o),
      .set_bus_o  (set_bus),
      .rb_index_o (rb_index),
      .rb_data_i  (rb_data)
   );

   readback_mux i_readback_mux (
      .wb_clk          (wb_clk),
      .soft_rst_i      (soft_rst),
      .rb_index_i      (rb_index),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .aux_ld_i        (aux_ld_i),
      .button_i        (button_i),
      .rb_data_o       (rb_data)
   );

   //////////////////////////////
   // Settings consumers
   //////////////////////////////
   settings_regs i_settings_regs (
      .wb_clk        (wb_clk),
      .soft_rst_i    (soft_rst),
      .set_bus_i     (set_bus),
      .run_i         (run_i),
      .lms_res_o     (lms_res_o),
      .phy_reset_n_o (phy_reset_n_o),
      .div_sw1_o     (div_sw1_o),
      .div_sw2_o     (div_sw2_o),
      .leds_o        (leds_o),
      .bldr_done_o   (bldr_done)
   );

   vita_timer i_vita_timer (
      .wb_clk          (wb_clk),
      .soft_rst_i      (soft_rst),
      .set_bus_i       (set_bus),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps)
   );

   boot_reset_ctrl i_boot_reset_ctrl (
      .wb_clk      (wb_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .soft_rst_o  (soft_rst)
   );

endmodule

/* verif/tb_umtrx_ctrl_core.sv */
/*
  Testbench for the wb_clk control plane.
  Acts as a Wishbone classic master, one access at a time, and checks
  outputs against a register model. Stimulus comes from a 16-bit LFSR.
  Time and PPS checks allow a window of cycles, not exact counts.
*/
`timescale 1ns/1ps

module tb_umtrx_ctrl_core;

   localparam int CLK_PERIOD   = 100;
   localparam int DRIVE_DLY    = 10;
   localparam int RESET_CYCLES = 10;
   localparam int ACK_LIMIT    = 16;
   localparam int N_WR         = 40;
   localparam int N_STAT       = 4;
   localparam int N_UNMAP      = 8;
   localparam int PPS_WAIT     = 10;
   // Writes, readback reads, time, PPS and boot accesses
   localparam int N_TRANS      = N_WR + N_STAT + 2 * N_UNMAP + 12 + 4 + 3 + 14;
   localparam int WATCHDOG_NS  = (N_TRANS * 200 + PPS_WAIT + RESET_CYCLES) * CLK_PERIOD;

   logic               wb_clk;
   logic               por_rst;
   core_pkg::wb_req_t  wb_req;
   core_pkg::wb_rsp_t  wb_rsp;
   logic [3:0]         run_i;
   logic               pps_i;
   logic [1:0]         aux_ld_i;
   logic               button_i;
   logic [1:0]         lms_res_o;
   logic               phy_reset_n_o;
   logic               div_sw1_o;
   logic               div_sw2_o;
   logic [7:0]         leds_o;

   logic [15:0] lfsr_q;
   int          errors;
   int          checks;

   // Register model
   logic [1:0]  m_lms;
   logic [7:0]  m_led_sw;
   logic [7:0]  m_led_src;
   logic        m_phy;
   logic        m_div1;
   logic        m_div2;

   umtrx_ctrl_core i_dut (
      .wb_clk        (wb_clk),
      .por_rst       (por_rst),
      .wb_req_i      (wb_req),
      .wb_rsp_o      (wb_rsp),
      .run_i         (run_i),
      .pps_i         (pps_i),
      .aux_ld_i      (aux_ld_i),
      .button_i      (button_i),
      .lms_res_o     (lms_res_o),
      .phy_reset_n_o (phy_reset_n_o),
      .div_sw1_o     (div_sw1_o),
      .div_sw2_o     (div_sw2_o),
      .leds_o        (leds_o)
   );

   initial begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Run timed out before all tests finished");
      $display("SIMULATION FAILED");
      $finish;
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////
   // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         v      = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [15:0] set_adr(input logic [7:0] a);
      return {6'b011100, a, 2'b00};
   endfunction

   function automatic logic [15:0] rb_adr(input logic [3:0] idx);
      return {8'h5C, 2'b00, idx, 2'b00};
   endfunction

   // Set source bits pick the run flags held in bits 4:1
   function automatic logic [7:0] exp_leds(input logic [7:0] src, input logic [7:0] sw,
                                           input logic [3:0] run);
      logic [7:0] hw;
      logic [7:0] mask;
      logic [7:0] res;
      int         b;
      hw  = 8'(run) << 1;
      res = '0;
      for (b = 0; b < 8; b++) begin
         mask = 8'(1 << b);
         if ((src & mask) != 8'd0) begin
            res = res | (hw & mask);
         end else begin
            res = res | (sw & mask);
         end
      end
      return res;
   endfunction

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic next_cycle();
      @(posedge wb_clk);
      #DRIVE_DLY;
   endtask

   task automatic wb_access(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int waits;
      waits      = 0;
      rdat       = '0;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.sel = 4'hF;
      wb_req.dat = wdat;
      do begin
         next_cycle();
         waits++;
      end while (!wb_rsp.ack && waits < ACK_LIMIT);
      if (wb_rsp.ack) begin
         rdat = wb_rsp.dat;
      end else begin
         $display("Bus access to address %h got no acknowledge", adr);
         errors++;
      end
      // Release in the cycle after ack
      next_cycle();
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   task automatic wb_write(input logic [15:0] adr, input logic [31:0] wdat);
      logic [31:0] unused;
      wb_access(1'b1, adr, wdat, unused);
   endtask

   task automatic wb_read(input logic [15:0] adr, output logic [31:0] rdat);
      wb_access(1'b0, adr, 32'd0, rdat);
   endtask

   task automatic model_reset();
      m_lms     = '0;
      m_led_sw  = '0;
      m_led_src = core_pkg::LED_SRC_RESET;
      m_phy     = 1'b0;
      m_div1    = core_pkg::DIVSW_RESET;
      m_div2    = core_pkg::DIVSW_RESET;
   endtask

   task automatic check_outputs();
      check("lms_res_o", 64'(lms_res_o), 64'(m_lms));
      check("phy_reset_n_o", 64'(phy_reset_n_o), 64'(!m_phy));
      check("div_sw1_o", 64'(div_sw1_o), 64'(m_div1));
      check("div_sw2_o", 64'(div_sw2_o), 64'(m_div2));
      check("leds_o", 64'(leds_o), 64'(exp_leds(m_led_src, m_led_sw, run_i)));
   endtask

   // Writes one register and updates the model to match
   task automatic set_write(input logic [7:0] a, input logic [31:0] d);
      wb_write(set_adr(a), d);
      case (a)
         core_pkg::SR_MISC + core_pkg::SR_LMS_RES_OFS: m_lms     = d[1:0];
         core_pkg::SR_MISC + core_pkg::SR_LED_SW_OFS:  m_led_sw  = d[7:0];
         core_pkg::SR_MISC + core_pkg::SR_PHY_OFS:     m_phy     = d[0];
         core_pkg::SR_MISC + core_pkg::SR_LED_SRC_OFS: m_led_src = d[7:0];
         core_pkg::SR_DIVSW:                           m_div1    = d[0];
         core_pkg::SR_DIVSW + 8'd1:                    m_div2    = d[0];
         default: begin
         end
      endcase
   endtask

   task automatic change_settings();
      set_write(core_pkg::SR_MISC + core_pkg::SR_LMS_RES_OFS, 32'd3);
      set_write(core_pkg::SR_MISC + core_pkg::SR_PHY_OFS, 32'd1);
      set_write(core_pkg::SR_MISC + core_pkg::SR_LED_SW_OFS, rand_bits(32));
      set_write(core_pkg::SR_MISC + core_pkg::SR_LED_SRC_OFS, rand_bits(32));
      set_write(core_pkg::SR_DIVSW, 32'd0);
      set_write(core_pkg::SR_DIVSW + 8'd1, 32'd0);
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////
   initial begin
      logic [31:0] d;
      logic [31:0] rd;
      logic [31:0] hi_wr;
      logic [31:0] lo_wr;
      logic [31:0] t_lo;
      logic [31:0] p_lo;
      logic [15:0] adr;
      logic [7:0]  a;
      logic [2:0]  kind;
      int          i;
      lfsr_q   = 16'd87;
      errors   = 0;
      checks   = 0;
      wb_req   = '0;
      por_rst  = 1'b1;
      run_i    = '0;
      pps_i    = 1'b0;
      aux_ld_i = '0;
      button_i = 1'b0;
      model_reset();
      repeat (RESET_CYCLES) @(posedge wb_clk);
      #DRIVE_DLY;
      por_rst = 1'b0;
      run_i   = 4'(rand_bits(4));
      repeat (2) next_cycle();

      // Reset values
      check("ack after reset", 64'(wb_rsp.ack), 64'd0);
      check_outputs();

      // Random settings writes to used and unused addresses
      for (i = 0; i < N_WR; i++) begin
         kind  = 3'(rand_bits(3));
         d     = rand_bits(32);
         run_i = 4'(rand_bits(4));
         case (kind)
            3'd0: a = core_pkg::SR_MISC + core_pkg::SR_LMS_RES_OFS;
            3'd1: a = core_pkg::SR_MISC + core_pkg::SR_LED_SW_OFS;
            3'd2: a = core_pkg::SR_MISC + core_pkg::SR_PHY_OFS;
            3'd3: a = core_pkg::SR_MISC + core_pkg::SR_LED_SRC_OFS;
            3'd4: a = core_pkg::SR_DIVSW;
            3'd5: a = core_pkg::SR_DIVSW + 8'd1;
            default: a = 8'(20 + rand_bits(5));
         endcase
         // Outputs are checked in the cycle after ack
         set_write(a, d);
         check_outputs();
      end

      // Readback words
      wb_read(rb_adr(core_pkg::RB_COMPAT), rd);
      check("compat word", 64'(rd), 64'(32'h0009_0000));
      for (i = 0; i < N_STAT; i++) begin
         aux_ld_i = 2'(rand_bits(2));
         button_i = 1'(rand_bits(1));
         wb_read(rb_adr(core_pkg::RB_MISC_STATUS), rd);
         d = (32'(aux_ld_i) << 17) | (32'(button_i) << 16);
         check("status word", 64'(rd), 64'(d));
      end
      for (i = 0; i < 10; i++) begin
         wb_read(rb_adr(4'(i)), rd);
         check("unused readback word", 64'(rd), 64'd0);
      end
      wb_read(set_adr(core_pkg::SR_MISC + core_pkg::SR_LED_SW_OFS), rd);
      check("settings window read", 64'(rd), 64'd0);
      for (i = 0; i < N_UNMAP; i++) begin
         adr = 16'(rand_bits(16));
         if ((adr[15:12] == 4'h7) || (adr[15:10] == 6'b010111)) begin
            adr[15] = 1'b1;
         end
         wb_write(adr, rand_bits(32));
         wb_read(adr, rd);
         check("unmapped read", 64'(rd), 64'd0);
      end
      check_outputs();

      // Time load with the low word clear of a carry
      hi_wr = rand_bits(32);
      lo_wr = rand_bits(32);
      if (lo_wr >= 32'hFFFF_0000) begin
         lo_wr = lo_wr & 32'h7FFF_FFFF;
      end
      wb_write(set_adr(core_pkg::SR_TIME64 + core_pkg::SR_TIME_HI_OFS), hi_wr);
      wb_write(set_adr(core_pkg::SR_TIME64 + core_pkg::SR_TIME_LO_OFS), lo_wr);
      wb_read(rb_adr(core_pkg::RB_TIME_HI), rd);
      check("time high", 64'(rd), 64'(hi_wr));
      wb_read(rb_adr(core_pkg::RB_TIME_LO), t_lo);
      check("time low within 1..64 of load",
            64'(((t_lo - lo_wr) >= 1) && ((t_lo - lo_wr) <= 64)), 64'd1);

      // PPS capture
      pps_i = 1'b1;
      repeat (2) next_cycle();
      pps_i = 1'b0;
      repeat (5) next_cycle();
      wb_read(rb_adr(core_pkg::RB_PPS_HI), rd);
      check("pps high", 64'(rd), 64'(hi_wr));
      wb_read(rb_adr(core_pkg::RB_PPS_LO), p_lo);
      wb_read(rb_adr(core_pkg::RB_TIME_LO), t_lo);
      check("pps low between load and now", 64'((p_lo >= lo_wr) && (p_lo <= t_lo)), 64'd1);

      // First bootloader done restarts the core
      change_settings();
      next_cycle();
      check_outputs();
      wb_write(set_adr(core_pkg::SR_MISC + core_pkg::SR_BLDR_OFS), 32'd1);
      repeat (4) next_cycle();
      model_reset();
      check_outputs();

      // Second one leaves the settings alone
      change_settings();
      wb_write(set_adr(core_pkg::SR_MISC + core_pkg::SR_BLDR_OFS), 32'd1);
      repeat (4) next_cycle();
      check_outputs();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
design/core_pkg.sv
design/wb_decoder.sv
design/settings_regs.sv
design/vita_timer.sv
design/readback_mux.sv
design/boot_reset_ctrl.sv
design/umtrx_ctrl_core.sv
verif/tb_umtrx_ctrl_core.sv

/* Makefile */
# Verilator build and run of the control plane testbench

VERILATOR ?= verilator
TOP       ?= tb_umtrx_ctrl_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
